// File: space_invader_top.f
design/game_pkg.sv
design/seq_pkg.sv
design/frame_ctrl_if.sv
design/frame_sequencer.sv
design/frame_timer.sv
design/player_ship.sv
design/alien_walker.sv
design/shot_unit.sv
design/pixel_writer.sv
design/space_invader_top.sv
tb/tb_clock.sv
tb/space_invader_tb.sv

// File: Makefile
TOP = space_invader_tb
SIM = obj_dir/V$(TOP)

all: run

$(SIM): space_invader_top.f $(wildcard design/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f space_invader_top.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb/space_invader_tb.sv
// Space invader testbench
module space_invader_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_frames = 150;   // Long enough for a shot to land and relaunch
  localparam int hold_left_frames = 80; // Ship reaches column 0 after 68
  localparam int screen_px = game_pkg::screen_w * game_pkg::screen_h;

  logic              clk;
  logic              rst;
  logic              go;
  logic              btn_left;
  logic              btn_right;
  logic              btn_fire;
  game_pkg::x_t      x;
  game_pkg::y_t      y;
  game_pkg::colour_t colour;
  logic              plot;

  // Reference model of the game positions
  int seed;
  int m_ship_x;
  int m_alien_x [game_pkg::num_aliens];
  int m_alien_y [game_pkg::num_aliens];
  bit m_alien_right [game_pkg::num_aliens];
  bit m_shot_fly;
  int m_shot_x;
  int m_shot_y;
  int launches;
  int landings;
  int turns;
  int clamp_hits;

  tb_clock tb_clock_inst (.clk(clk), .rst(rst));

  space_invader_top #(.tick_cycles(40)) space_invader_top_inst (
    .clk(clk), .rst(rst), .go(go),
    .btn_left(btn_left), .btn_right(btn_right), .btn_fire(btn_fire),
    .x(x), .y(y), .colour(colour), .plot(plot)
  );

  task automatic check_value(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "wait timed out");
  endtask

  // Samples on the falling edge until plot rises
  task automatic wait_for_plot(input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!plot) begin
      n++;
      if (n > limit)
        report_timeout(what);
      @(negedge clk);
    end
  endtask

  task automatic check_pixel(input int ex, input int ey, input int ec, input string what);
    check_value(int'(plot), 1, {what, " plot"});
    check_value(int'(x), ex, {what, " x"});
    check_value(int'(y), ey, {what, " y"});
    check_value(int'(colour), ec, {what, " colour"});
  endtask

  task automatic apply_update(input bit l, input bit r, input bit fire);
    // Shot first, it launches from the ship column before the move
    if (m_shot_fly) begin
      if (m_shot_y == 0) begin
        m_shot_fly = 1'b0;
        landings++;
      end else begin
        m_shot_y--;
      end
    end else if (fire) begin
      m_shot_fly = 1'b1;
      m_shot_x   = m_ship_x;
      m_shot_y   = int'(game_pkg::ship_row) - 1;
      launches++;
    end
    if (l && !r && m_ship_x == 0)
      clamp_hits++;
    if (l && !r && m_ship_x > 0)
      m_ship_x--;
    else if (r && !l && m_ship_x < game_pkg::screen_w - 1)
      m_ship_x++;
    for (int i = 0; i < game_pkg::num_aliens; i++) begin
      if (m_alien_right[i] && m_alien_x[i] == int'(game_pkg::lane_right[i])) begin
        m_alien_right[i] = 1'b0;
        m_alien_y[i]++;
        turns++;
      end else if (!m_alien_right[i] && m_alien_x[i] == int'(game_pkg::lane_left[i])) begin
        m_alien_right[i] = 1'b1;
        m_alien_y[i]++;
        turns++;
      end else begin
        m_alien_x[i] += m_alien_right[i] ? 1 : -1;
      end
    end
  endtask

  initial begin
    int n;
    bit l;
    bit r;
    bit fire;
    go        = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    seed      = 32'h9d31;
    m_ship_x  = int'(game_pkg::ship_x0);
    m_shot_fly = 1'b0;
    m_shot_x  = 0;
    m_shot_y  = 0;
    launches  = 0;
    landings  = 0;
    turns     = 0;
    clamp_hits = 0;
    for (int i = 0; i < game_pkg::num_aliens; i++) begin
      m_alien_x[i]     = int'(game_pkg::lane_left[i]);
      m_alien_y[i]     = int'(game_pkg::alien_row0);
      m_alien_right[i] = 1'b1;
    end

    n = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > 10)
        report_timeout("reset release");
    end

    // Idle with go low
    repeat (20) begin
      @(negedge clk);
      check_value(int'(plot), 0, "plot while idle");
    end
    @(posedge clk);
    go <= 1'b1;

    for (int f = 0; f < num_frames; f++) begin
      wait_for_plot(10, "ship pixel");
      check_pixel(m_ship_x, int'(game_pkg::ship_row), int'(game_pkg::col_green), "ship");
      if (f < hold_left_frames) begin
        l = 1'b1;
        r = 1'b0;
      end else begin
        l = ($random(seed) & 1) != 0;
        r = ($random(seed) & 1) != 0;
      end
      fire = ($random(seed) & 3) != 0;
      @(posedge clk); // Held until this frame's update
      btn_left  <= l;
      btn_right <= r;
      btn_fire  <= fire;
      for (int i = 0; i < game_pkg::num_aliens; i++) begin
        @(negedge clk);
        check_pixel(m_alien_x[i], m_alien_y[i], int'(game_pkg::col_red), "alien");
      end
      if (m_shot_fly) begin
        @(negedge clk);
        check_pixel(m_shot_x, m_shot_y, int'(game_pkg::col_white), "shot");
      end
      @(negedge clk);
      check_value(int'(plot), 0, "plot after frame objects");

      wait_for_plot(100, "screen clear");
      for (int p = 0; p < screen_px; p++) begin
        if (p > 0)
          @(negedge clk);
        check_pixel(p % game_pkg::screen_w, p / game_pkg::screen_w,
                    int'(game_pkg::col_black), "clear");
      end
      @(negedge clk);
      check_value(int'(plot), 0, "plot after clear");
      apply_update(l, r, fire);
    end

    check_value(int'(clamp_hits > 0), 1, "ship held at left edge");
    check_value(int'(turns > 0), 1, "alien lane turns seen");
    check_value(int'(landings > 0), 1, "shot landings seen");
    check_value(int'(launches >= 2), 1, "launch after landing seen");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk); // Two cycles in reset
    rst <= 1'b0;
  end

endmodule

// File: design/space_invader_top.sv
// Space invader game core
module space_invader_top #(
  parameter int unsigned tick_cycles = 833333
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               go,
  input  logic               btn_left,
  input  logic               btn_right,
  input  logic               btn_fire,
  output game_pkg::x_t       x,
  output game_pkg::y_t       y,
  output game_pkg::colour_t  colour,
  output logic               plot
);

  logic tick;
  logic clear_done;
  logic shot_flying;

  game_pkg::x_t ship_x;
  game_pkg::y_t ship_y;
  game_pkg::x_t alien_x [game_pkg::num_aliens];
  game_pkg::y_t alien_y [game_pkg::num_aliens];
  game_pkg::x_t shot_x;
  game_pkg::y_t shot_y;

  frame_ctrl_if ctrl ();

  frame_sequencer frame_sequencer_inst (
    .clk(clk), .rst(rst), .go(go), .tick(tick), .clear_done(clear_done),
    .shot_flying(shot_flying), .ctrl(ctrl.seq)
  );

  frame_timer #(.tick_cycles(tick_cycles)) frame_timer_inst (
    .clk(clk), .rst(rst), .ctrl(ctrl.dp), .tick(tick)
  );

  player_ship player_ship_inst (
    .clk(clk), .rst(rst), .btn_left(btn_left), .btn_right(btn_right),
    .ctrl(ctrl.dp), .x(ship_x), .y(ship_y)
  );

  for (genvar i = 0; i < game_pkg::num_aliens; i++) begin : g_alien
    alien_walker #(
      .alien_left(game_pkg::lane_left[i]),
      .alien_right(game_pkg::lane_right[i])
    ) alien_walker_inst (
      .clk(clk), .rst(rst), .ctrl(ctrl.dp), .x(alien_x[i]), .y(alien_y[i])
    );
  end

  shot_unit shot_unit_inst (
    .clk(clk), .rst(rst), .btn_fire(btn_fire), .ship_x(ship_x), .ctrl(ctrl.dp),
    .x(shot_x), .y(shot_y), .shot_flying(shot_flying)
  );

  pixel_writer pixel_writer_inst (
    .clk(clk), .rst(rst), .ctrl(ctrl.dp),
    .ship_x(ship_x), .ship_y(ship_y), .alien_x(alien_x), .alien_y(alien_y),
    .shot_x(shot_x), .shot_y(shot_y),
    .x(x), .y(y), .colour(colour), .plot(plot), .clear_done(clear_done)
  );

endmodule

// File: design/pixel_writer.sv
// Pixel write stage and screen clear
module pixel_writer (
  input  logic                clk,
  input  logic                rst,
  frame_ctrl_if.dp            ctrl,
  input  game_pkg::x_t        ship_x,
  input  game_pkg::y_t        ship_y,
  input  game_pkg::x_t        alien_x [game_pkg::num_aliens],
  input  game_pkg::y_t        alien_y [game_pkg::num_aliens],
  input  game_pkg::x_t        shot_x,
  input  game_pkg::y_t        shot_y,
  output game_pkg::x_t        x,
  output game_pkg::y_t        y,
  output game_pkg::colour_t   colour,
  output logic                plot,
  output logic                clear_done
);

  localparam game_pkg::x_t x_last = game_pkg::x_t'(game_pkg::screen_w - 1);
  localparam game_pkg::y_t y_last = game_pkg::y_t'(game_pkg::screen_h - 1);

  game_pkg::x_t clr_x; // Raster position of the sweep
  game_pkg::y_t clr_y;

  assign clear_done = ctrl.clear_en && clr_x == x_last && clr_y == y_last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      plot  <= 1'b0;
      clr_x <= '0;
      clr_y <= '0;
    end else begin
      plot <= ctrl.clear_en || ctrl.plot_src != seq_pkg::src_none;
      if (ctrl.clear_en) begin
        if (clr_x == x_last) begin
          clr_x <= '0;
          clr_y <= (clr_y == y_last) ? '0 : clr_y + 7'd1;
        end else begin
          clr_x <= clr_x + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    case (ctrl.plot_src)
      seq_pkg::src_ship:   {x, y, colour} <= {ship_x, ship_y, game_pkg::col_green};
      seq_pkg::src_alien0: {x, y, colour} <= {alien_x[0], alien_y[0], game_pkg::col_red};
      seq_pkg::src_alien1: {x, y, colour} <= {alien_x[1], alien_y[1], game_pkg::col_red};
      seq_pkg::src_alien2: {x, y, colour} <= {alien_x[2], alien_y[2], game_pkg::col_red};
      seq_pkg::src_shot:   {x, y, colour} <= {shot_x, shot_y, game_pkg::col_white};
      default: begin
        if (ctrl.clear_en)
          {x, y, colour} <= {clr_x, clr_y, game_pkg::col_black};
      end
    endcase
  end

  // Sweep and object plots never overlap
  a_clear_excl: assert property (@(posedge clk) disable iff (rst)
    ctrl.clear_en |-> ctrl.plot_src == seq_pkg::src_none);

endmodule

// File: design/shot_unit.sv
// Player bullet
module shot_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic           btn_fire,
  input  game_pkg::x_t   ship_x,
  frame_ctrl_if.dp       ctrl,
  output game_pkg::x_t   x,
  output game_pkg::y_t   y,
  output logic           shot_flying
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shot_flying <= 1'b0;
      x           <= game_pkg::ship_x0;
      y           <= game_pkg::ship_row;
    end else if (ctrl.update_en) begin
      if (shot_flying) begin
        if (y == '0)
          shot_flying <= 1'b0; // Left the top of the screen
        else
          y <= y - 7'd1;
      end else if (btn_fire) begin
        shot_flying <= 1'b1;
        x           <= ship_x; // Column before the ship moves
        y           <= game_pkg::ship_row - 7'd1;
      end
    end
  end

  a_shot_on_screen: assert property (@(posedge clk) disable iff (rst)
    y < game_pkg::y_t'(game_pkg::screen_h));

endmodule

// File: design/alien_walker.sv
// Alien lane walker
module alien_walker #(
  parameter game_pkg::x_t alien_left  = game_pkg::lane_left[0],
  parameter game_pkg::x_t alien_right = game_pkg::lane_right[0]
) (
  input  logic           clk,
  input  logic           rst,
  frame_ctrl_if.dp       ctrl,
  output game_pkg::x_t   x,
  output game_pkg::y_t   y
);

  logic dir_right;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      x         <= alien_left;
      y         <= game_pkg::alien_row0;
      dir_right <= 1'b1;
    end else if (ctrl.update_en) begin
      if (dir_right && x == alien_right) begin
        dir_right <= 1'b0; // Turn costs a frame, no sideways step
        y         <= y + 7'd1;
      end else if (!dir_right && x == alien_left) begin
        dir_right <= 1'b1;
        y         <= y + 7'd1;
      end else if (dir_right) begin
        x <= x + 8'd1;
      end else begin
        x <= x - 8'd1;
      end
    end
  end

endmodule

// File: design/player_ship.sv
// Player ship movement
module player_ship (
  input  logic           clk,
  input  logic           rst,
  input  logic           btn_left,
  input  logic           btn_right,
  frame_ctrl_if.dp       ctrl,
  output game_pkg::x_t   x,
  output game_pkg::y_t   y
);

  localparam game_pkg::x_t x_last = game_pkg::x_t'(game_pkg::screen_w - 1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      x <= game_pkg::ship_x0;
    end else if (ctrl.update_en) begin
      // Both buttons together cancel out
      if (btn_left && !btn_right && x != '0)
        x <= x - 8'd1;
      else if (btn_right && !btn_left && x != x_last)
        x <= x + 8'd1;
    end
  end

  assign y = game_pkg::ship_row;

endmodule

// File: design/frame_timer.sv
// Move tick timer
module frame_timer #(
  parameter int unsigned tick_cycles = 833333
) (
  input  logic      clk,
  input  logic      rst,
  frame_ctrl_if.dp  ctrl,
  output logic      tick
);

  localparam int cnt_w = $clog2(tick_cycles + 1);

  logic [cnt_w-1:0] cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (ctrl.timer_clr) begin
        cnt <= '0;
      end else if (ctrl.in_game && cnt != cnt_w'(tick_cycles)) begin
        cnt  <= cnt + 1'b1;
        tick <= (cnt == cnt_w'(tick_cycles - 1)); // Fires once, then the count parks
      end
    end
  end

endmodule

// File: design/frame_sequencer.sv
// Game frame FSM
module frame_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             go,
  input  logic             tick,
  input  logic             clear_done,
  input  logic             shot_flying,
  frame_ctrl_if.seq        ctrl
);

  localparam logic [1:0] last_alien = 2'(game_pkg::num_aliens - 1);

  seq_pkg::seq_state_t state, state_nxt;
  logic [1:0] alien_idx; // Alien being plotted

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= seq_pkg::st_idle;
      alien_idx <= 2'd0;
    end else begin
      state     <= state_nxt;
      alien_idx <= (state == seq_pkg::st_plot_alien) ? alien_idx + 2'd1 : 2'd0;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      seq_pkg::st_idle:       if (go) state_nxt = seq_pkg::st_start;
      seq_pkg::st_start:      state_nxt = seq_pkg::st_plot_ship;
      seq_pkg::st_plot_ship:  state_nxt = seq_pkg::st_plot_alien;
      seq_pkg::st_plot_alien: begin
        if (alien_idx == last_alien)
          state_nxt = shot_flying ? seq_pkg::st_plot_shot : seq_pkg::st_wait_tick;
      end
      seq_pkg::st_plot_shot:  state_nxt = seq_pkg::st_wait_tick;
      seq_pkg::st_wait_tick:  if (tick) state_nxt = seq_pkg::st_clear;
      seq_pkg::st_clear:      if (clear_done) state_nxt = seq_pkg::st_update;
      seq_pkg::st_update:     state_nxt = seq_pkg::st_start; // Next frame
      default:                state_nxt = seq_pkg::st_idle;
    endcase
  end

  // Commands are decoded straight from the state
  always_comb begin
    ctrl.plot_src = seq_pkg::src_none;
    case (state)
      seq_pkg::st_plot_ship:  ctrl.plot_src = seq_pkg::src_ship;
      seq_pkg::st_plot_alien: begin
        case (alien_idx)
          2'd0:    ctrl.plot_src = seq_pkg::src_alien0;
          2'd1:    ctrl.plot_src = seq_pkg::src_alien1;
          default: ctrl.plot_src = seq_pkg::src_alien2;
        endcase
      end
      seq_pkg::st_plot_shot:  ctrl.plot_src = seq_pkg::src_shot;
      default:                ctrl.plot_src = seq_pkg::src_none;
    endcase
  end

  assign ctrl.in_game   = (state != seq_pkg::st_idle);
  assign ctrl.timer_clr = (state == seq_pkg::st_start);
  assign ctrl.clear_en  = (state == seq_pkg::st_clear);
  assign ctrl.update_en = (state == seq_pkg::st_update);

  // Positions only move straight after a full sweep
  a_update_after_clear: assert property (@(posedge clk) disable iff (rst)
    ctrl.update_en |-> $past(clear_done));

endmodule

// File: design/frame_ctrl_if.sv
// Per-frame command bundle
interface frame_ctrl_if;

  logic                in_game;   // High once a game has started
  seq_pkg::plot_src_t  plot_src;
  logic                clear_en;  // Held through the screen sweep
  logic                update_en; // Single cycle, moves everything
  logic                timer_clr;

  modport seq (
    output in_game, plot_src, clear_en, update_en, timer_clr
  );

  modport dp (
    input in_game, plot_src, clear_en, update_en, timer_clr
  );

endinterface

// File: design/seq_pkg.sv
// Frame sequencer types
package seq_pkg;

  typedef enum logic [2:0] {
    st_idle, st_start, st_plot_ship, st_plot_alien,
    st_plot_shot, st_wait_tick, st_clear, st_update
  } seq_state_t;

  // Which object the pixel writer draws this cycle
  typedef enum logic [2:0] {
    src_none, src_ship, src_alien0, src_alien1, src_alien2, src_shot
  } plot_src_t;

endpackage

// File: design/game_pkg.sv
// Game geometry and colours
package game_pkg;

  localparam int screen_w = 160;
  localparam int screen_h = 120;
  localparam int num_aliens = 3;

  typedef logic [7:0] x_t; // Column
  typedef logic [6:0] y_t; // Row
  typedef logic [2:0] colour_t; // RGB, one bit each

  localparam colour_t col_black = 3'b000;
  localparam colour_t col_green = 3'b010;
  localparam colour_t col_red   = 3'b100;
  localparam colour_t col_white = 3'b111;

  localparam x_t ship_x0    = 8'd68;
  localparam y_t ship_row   = 7'd111; // Ship never leaves this row
  localparam y_t alien_row0 = 7'd15;

  // Each alien walks inside its own lane
  localparam x_t lane_left  [num_aliens] = '{8'd50, 8'd70, 8'd90};
  localparam x_t lane_right [num_aliens] = '{8'd69, 8'd89, 8'd109};

endpackage
